// ==== verilog/CorePkg.sv ====
package CorePkg;

    localparam int DataWidth = 32;
    localparam int RegNmBits = 5;

    localparam int RobDepthDefault = 8;
    localparam int RsDepthDefault = 4;
    localparam int QueueDepthDefault = 4;

    // Tag fields in the shared structs follow the default buffer depth
    localparam int TagBits = $clog2(RobDepthDefault);

    localparam logic [6:0] OpcodeOp = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm = 7'b0010011;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluSrl,
        AluInvalid
    } AluOp;

    typedef struct packed {
        logic [6:0] funct7;
        logic [RegNmBits-1:0] rs2;
        logic [RegNmBits-1:0] rs1;
        logic [2:0] funct3;
        logic [RegNmBits-1:0] rd;
        logic [6:0] opcode;
    } RTypeFields;

    typedef struct packed {
        logic [11:0] imm12;
        logic [RegNmBits-1:0] rs1;
        logic [2:0] funct3;
        logic [RegNmBits-1:0] rd;
        logic [6:0] opcode;
    } ITypeFields;

    typedef union packed {
        RTypeFields r;
        ITypeFields i;
    } InstrWord;

    typedef struct packed {
        logic valid;
        AluOp aluOp;
        logic [RegNmBits-1:0] rs1;
        logic [RegNmBits-1:0] rs2;
        logic [RegNmBits-1:0] rd;
        logic immB;
        logic [DataWidth-1:0] imm;
        logic invalid;
    } DecodedUop;

    // A source operand, either a value or the tag it still waits for
    typedef struct packed {
        logic [DataWidth-1:0] value;
        logic [TagBits-1:0] tag;
        logic avail;
    } Operand;

    typedef struct packed {
        AluOp aluOp;
        Operand opA;
        Operand opB;
        logic [TagBits-1:0] tagDst;
    } IssueUop;

    typedef struct packed {
        logic valid;
        logic [TagBits-1:0] tag;
        logic [DataWidth-1:0] value;
    } ResultBus;

    typedef struct packed {
        logic done;
        logic [DataWidth-1:0] value;
    } RobRead;

    typedef struct packed {
        logic valid;
        logic [RegNmBits-1:0] rd;
        logic [DataWidth-1:0] value;
        logic invalid;
    } CommitPort;

endpackage

// ==== verilog/InstrDecoder.sv ====
`timescale 1ns/100ps

module InstrDecoder #(
    parameter int QueueDepth = CorePkg::QueueDepthDefault
) (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input CorePkg::InstrWord instr,
    input logic pop,
    output CorePkg::DecodedUop head,
    output logic creditReturn
);
    import CorePkg::*;

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountW = $clog2(QueueDepth + 1);

    InstrWord queue [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CountW-1:0] count;
    InstrWord word;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Operations shared by the register and immediate forms
    function automatic AluOp commonOp(input logic [2:0] funct3);
        case (funct3)
            3'b000: return AluAdd;
            3'b111: return AluAnd;
            3'b110: return AluOr;
            3'b100: return AluXor;
            3'b010: return AluSlt;
            default: return AluInvalid;
        endcase
    endfunction

    // Each credit leaves with the instruction that used it
    assign creditReturn = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (instrValid) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            count <= count + CountW'(instrValid) - CountW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) queue[wrPtr] <= instr;
    end

    always_comb begin
        word = queue[rdPtr];
        head = '0;
        head.valid = count != '0;
        head.aluOp = AluInvalid;
        case (word.r.opcode)
            OpcodeOp: begin
                head.rs1 = word.r.rs1;
                head.rs2 = word.r.rs2;
                head.rd = word.r.rd;
                if (word.r.funct7 == 7'h00) begin
                    case (word.r.funct3)
                        3'b001: head.aluOp = AluSll;
                        3'b101: head.aluOp = AluSrl;
                        default: head.aluOp = commonOp(word.r.funct3);
                    endcase
                end else if (word.r.funct7 == 7'h20 && word.r.funct3 == 3'b000) begin
                    head.aluOp = AluSub;
                end
            end
            OpcodeOpImm: begin
                head.rs1 = word.i.rs1;
                head.rd = word.i.rd;
                head.immB = 1'b1;
                head.imm = {{(DataWidth - 12){word.i.imm12[11]}}, word.i.imm12};
                head.aluOp = commonOp(word.i.funct3);
            end
            default: ;
        endcase
        head.invalid = head.aluOp == AluInvalid;
        // An invalid word names no registers at all
        if (head.invalid) begin
            head.rs1 = '0;
            head.rs2 = '0;
            head.rd = '0;
        end
    end

endmodule

// ==== verilog/RenameTable.sv ====
`timescale 1ns/100ps

module RenameTable #(
    parameter int RobDepth = CorePkg::RobDepthDefault,
    localparam int TagW = $clog2(RobDepth)
) (
    input logic clk,
    input logic rst,
    input logic [CorePkg::RegNmBits-1:0] rs1,
    input logic [CorePkg::RegNmBits-1:0] rs2,
    output CorePkg::Operand lookupA,
    output CorePkg::Operand lookupB,
    input logic wrEn,
    input logic [CorePkg::RegNmBits-1:0] wrRd,
    input logic [TagW-1:0] wrTag,
    input CorePkg::CommitPort commit,
    input logic [TagW-1:0] commitTag
);
    import CorePkg::*;

    localparam int NumRegs = 2 ** RegNmBits;

    logic [DataWidth-1:0] values [NumRegs];
    logic [TagW-1:0] tags [NumRegs];
    logic [NumRegs-1:0] avail;

    // Register 0 is never written, so it keeps reading 0 and available
    always_comb begin
        lookupA.value = values[rs1];
        lookupA.tag = tags[rs1];
        lookupA.avail = avail[rs1];
        lookupB.value = values[rs2];
        lookupB.tag = tags[rs2];
        lookupB.avail = avail[rs2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NumRegs; r++) begin
                values[r] <= '0;
                tags[r] <= '0;
            end
            avail <= '1;
        end else begin
            if (commit.valid && commit.rd != '0) begin
                values[commit.rd] <= commit.value;
                // A younger producer of the same register keeps it pending
                if (tags[commit.rd] == commitTag) avail[commit.rd] <= 1'b1;
            end
            // Dispatch comes last so it wins over a commit to the same register
            if (wrEn && wrRd != '0) begin
                avail[wrRd] <= 1'b0;
                tags[wrRd] <= wrTag;
            end
        end
    end

endmodule

// ==== verilog/ReservationStation.sv ====
`timescale 1ns/100ps

module ReservationStation #(
    parameter int RsDepth = CorePkg::RsDepthDefault,
    parameter int RobDepth = CorePkg::RobDepthDefault
) (
    input logic clk,
    input logic rst,
    input logic insert,
    input CorePkg::IssueUop insUop,
    input CorePkg::ResultBus result,
    output logic full,
    output logic issueValid,
    output CorePkg::IssueUop issueUop
);
    import CorePkg::*;

    localparam int TagW = $clog2(RobDepth);
    localparam int IdxW = (RsDepth > 1) ? $clog2(RsDepth) : 1;
    localparam int CountW = $clog2(RsDepth + 1);

    IssueUop entries [RsDepth];
    logic [RsDepth-1:0] valid;
    // Age is the number of older entries still waiting
    logic [IdxW-1:0] age [RsDepth];
    logic [IdxW-1:0] issueIdx;
    logic [IdxW-1:0] freeIdx;
    logic [CountW-1:0] validCount;
    IssueUop insWoken;

    function automatic Operand wake(input Operand op, input ResultBus res);
        Operand woken;
        woken = op;
        if (!op.avail && res.valid && TagW'(op.tag) == TagW'(res.tag)) begin
            woken.value = res.value;
            woken.avail = 1'b1;
        end
        return woken;
    endfunction

    assign full = &valid;
    assign issueUop = entries[issueIdx];

    always_comb begin
        issueValid = 1'b0;
        issueIdx = '0;
        freeIdx = '0;
        validCount = '0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (!valid[i]) freeIdx = IdxW'(i);
            validCount = validCount + CountW'(valid[i]);
        end
        for (int i = 0; i < RsDepth; i++) begin
            if (valid[i] && entries[i].opA.avail && entries[i].opB.avail &&
                (!issueValid || age[i] < age[issueIdx])) begin
                issueValid = 1'b1;
                issueIdx = IdxW'(i);
            end
        end
    end

    always_comb begin
        insWoken = insUop;
        insWoken.opA = wake(insUop.opA, result);
        insWoken.opB = wake(insUop.opB, result);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < RsDepth; i++) age[i] <= '0;
        end else begin
            for (int i = 0; i < RsDepth; i++) begin
                if (issueValid && issueIdx == IdxW'(i)) begin
                    valid[i] <= 1'b0;
                end else if (valid[i] && issueValid && age[i] > age[issueIdx]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (insert) begin
                valid[freeIdx] <= 1'b1;
                age[freeIdx] <= IdxW'(validCount - CountW'(issueValid));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RsDepth; i++) begin
            entries[i].opA <= wake(entries[i].opA, result);
            entries[i].opB <= wake(entries[i].opB, result);
        end
        if (insert) entries[freeIdx] <= insWoken;
    end

endmodule

// ==== verilog/IntAlu.sv ====
`timescale 1ns/100ps

module IntAlu #(
    parameter int RobDepth = CorePkg::RobDepthDefault
) (
    input logic clk,
    input logic rst,
    input logic issueValid,
    input CorePkg::IssueUop issueUop,
    output CorePkg::ResultBus result
);
    import CorePkg::*;

    localparam int TagW = $clog2(RobDepth);

    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    logic [DataWidth-1:0] aluOut;
    logic validQ;
    logic [TagW-1:0] tagQ;
    logic [DataWidth-1:0] valueQ;

    assign a = issueUop.opA.value;
    assign b = issueUop.opB.value;

    always_comb begin
        case (issueUop.aluOp)
            AluAdd: aluOut = a + b;
            AluSub: aluOut = a - b;
            AluAnd: aluOut = a & b;
            AluOr: aluOut = a | b;
            AluXor: aluOut = a ^ b;
            AluSlt: aluOut = {{(DataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
            // Shift amounts only use the low five bits
            AluSll: aluOut = a << b[4:0];
            AluSrl: aluOut = a >> b[4:0];
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) validQ <= 1'b0;
        else validQ <= issueValid;
        tagQ <= issueUop.tagDst;
        valueQ <= aluOut;
    end

    assign result = '{valid: validQ, tag: tagQ, value: valueQ};

endmodule

// ==== verilog/ReorderBuffer.sv ====
`timescale 1ns/100ps

module ReorderBuffer #(
    parameter int RobDepth = CorePkg::RobDepthDefault,
    localparam int TagW = $clog2(RobDepth)
) (
    input logic clk,
    input logic rst,
    input logic alloc,
    input logic [CorePkg::RegNmBits-1:0] allocRd,
    input logic allocInvalid,
    output logic [TagW-1:0] allocTag,
    output logic full,
    input CorePkg::ResultBus result,
    input logic [TagW-1:0] readTagA,
    input logic [TagW-1:0] readTagB,
    output CorePkg::RobRead readA,
    output CorePkg::RobRead readB,
    output CorePkg::CommitPort commit,
    output logic [TagW-1:0] commitTag
);
    import CorePkg::*;

    logic [TagW-1:0] headPtr;
    logic [TagW-1:0] tailPtr;
    logic [TagW:0] count;
    logic [RobDepth-1:0] done;
    logic [RobDepth-1:0] invalidQ;
    logic [RegNmBits-1:0] rdQ [RobDepth];
    logic [DataWidth-1:0] valueQ [RobDepth];
    logic doCommit;
    logic [TagW-1:0] resTag;

    // The slot index doubles as the tag, so the depth is a power of two
    assign allocTag = tailPtr;
    assign commitTag = headPtr;
    assign full = count == (TagW + 1)'(RobDepth);
    assign resTag = TagW'(result.tag);

    assign doCommit = count != '0 && done[headPtr];

    always_comb begin
        commit.valid = doCommit;
        commit.rd = rdQ[headPtr];
        commit.value = valueQ[headPtr];
        commit.invalid = invalidQ[headPtr];
    end

    // done is cleared at commit, so it only holds for live slots
    always_comb begin
        readA.done = done[readTagA];
        readA.value = valueQ[readTagA];
        readB.done = done[readTagB];
        readB.value = valueQ[readTagB];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            done <= '0;
        end else begin
            if (result.valid) done[resTag] <= 1'b1;
            if (doCommit) begin
                done[headPtr] <= 1'b0;
                headPtr <= headPtr + 1'b1;
            end
            // Invalid words have nothing to wait for
            if (alloc) begin
                done[tailPtr] <= allocInvalid;
                tailPtr <= tailPtr + 1'b1;
            end
            count <= count + (TagW + 1)'(alloc) - (TagW + 1)'(doCommit);
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) valueQ[resTag] <= result.value;
        if (alloc) begin
            rdQ[tailPtr] <= allocRd;
            invalidQ[tailPtr] <= allocInvalid;
            valueQ[tailPtr] <= '0;
        end
    end

endmodule

// ==== verilog/Core.sv ====
`timescale 1ns/100ps

module Core #(
    parameter int QueueDepth = CorePkg::QueueDepthDefault,
    parameter int RsDepth = CorePkg::RsDepthDefault,
    parameter int RobDepth = CorePkg::RobDepthDefault
) (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input CorePkg::InstrWord instr,
    output logic creditReturn,
    output CorePkg::CommitPort commit
);
    import CorePkg::*;

    localparam int TagW = $clog2(RobDepth);

    DecodedUop head;
    Operand lookupA;
    Operand lookupB;
    RobRead readA;
    RobRead readB;
    ResultBus result;
    IssueUop insUop;
    IssueUop issueUop;
    logic issueValid;
    logic [TagW-1:0] allocTag;
    logic [TagW-1:0] commitTag;
    logic rsFull;
    logic robFull;
    logic dispatch;
    logic execDispatch;

    // A pending operand is taken from the result bus first, then from the ROB
    function automatic Operand pickOperand(input Operand lookup, input ResultBus res,
                                           input RobRead rob);
        Operand op;
        op = lookup;
        if (!lookup.avail) begin
            if (res.valid && TagW'(res.tag) == TagW'(lookup.tag)) begin
                op.value = res.value;
                op.avail = 1'b1;
            end else if (rob.done) begin
                op.value = rob.value;
                op.avail = 1'b1;
            end
        end
        return op;
    endfunction

    assign dispatch = head.valid && !rsFull && !robFull;
    // Invalid words only take a ROB slot
    assign execDispatch = dispatch && !head.invalid;

    always_comb begin
        insUop.aluOp = head.aluOp;
        insUop.tagDst = allocTag;
        insUop.opA = pickOperand(lookupA, result, readA);
        insUop.opB = pickOperand(lookupB, result, readB);
        if (head.immB) begin
            insUop.opB.value = head.imm;
            insUop.opB.avail = 1'b1;
        end
    end

    InstrDecoder #(.QueueDepth(QueueDepth)) decoder (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .pop(dispatch),
        .head(head),
        .creditReturn(creditReturn)
    );

    RenameTable #(.RobDepth(RobDepth)) renameTable (
        .clk(clk),
        .rst(rst),
        .rs1(head.rs1),
        .rs2(head.rs2),
        .lookupA(lookupA),
        .lookupB(lookupB),
        .wrEn(execDispatch),
        .wrRd(head.rd),
        .wrTag(allocTag),
        .commit(commit),
        .commitTag(commitTag)
    );

    ReservationStation #(.RsDepth(RsDepth), .RobDepth(RobDepth)) rs (
        .clk(clk),
        .rst(rst),
        .insert(execDispatch),
        .insUop(insUop),
        .result(result),
        .full(rsFull),
        .issueValid(issueValid),
        .issueUop(issueUop)
    );

    IntAlu #(.RobDepth(RobDepth)) alu (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .result(result)
    );

    ReorderBuffer #(.RobDepth(RobDepth)) rob (
        .clk(clk),
        .rst(rst),
        .alloc(dispatch),
        .allocRd(head.rd),
        .allocInvalid(head.invalid),
        .allocTag(allocTag),
        .full(robFull),
        .result(result),
        .readTagA(TagW'(lookupA.tag)),
        .readTagB(TagW'(lookupB.tag)),
        .readA(readA),
        .readB(readB),
        .commit(commit),
        .commitTag(commitTag)
    );

endmodule

// ==== tb/Core_chk.sv ====
`timescale 1ns/100ps

module Core_chk #(
    parameter int RobDepth = CorePkg::RobDepthDefault,
    localparam int TagW = $clog2(RobDepth)
) (
    input logic clk,
    input logic rst,
    input logic alloc,
    input logic full,
    input logic commitValid,
    input logic [TagW:0] count,
    input logic [TagW-1:0] headPtr,
    input logic [TagW-1:0] tailPtr,
    input logic resultValid,
    input logic [TagW-1:0] resTag,
    input logic [RobDepth-1:0] done
);

    // Equal pointers mean an empty buffer unless the count says it is full
    commitNotEmpty: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> (headPtr != tailPtr || full))
        else $error("ROB committed while it held no entry");

    allocNotFull: assert property (@(posedge clk) disable iff (rst)
        alloc |-> (headPtr != tailPtr || count == '0))
        else $error("ROB allocated a slot while full");

    // Each slot gets exactly one result between allocation and commit
    captureOnce: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> !done[resTag])
        else $error("ROB slot received a second result");

endmodule

bind ReorderBuffer Core_chk #(.RobDepth(RobDepth)) robChk (
    .clk(clk),
    .rst(rst),
    .alloc(alloc),
    .full(full),
    .commitValid(commit.valid),
    .count(count),
    .headPtr(headPtr),
    .tailPtr(tailPtr),
    .resultValid(result.valid),
    .resTag(resTag),
    .done(done)
);

// ==== tb/CoreTb.sv ====
`timescale 1ns/100ps

module CoreTb;
    import CorePkg::*;

    localparam int QueueDepth = 4;
    localparam int RsDepth = 4;
    localparam int RobDepth = 8;
    localparam int NumInstr = 2000;
    localparam int StallTimeout = 500;
    localparam int DrainTimeout = 2000;

    logic clk;
    logic rst;
    logic instrValid;
    InstrWord instr;
    logic creditReturn;
    CommitPort commit;

    logic [DataWidth-1:0] regs [32];
    CommitPort expected [$];
    int credits;
    int sent;
    int committed;

    Core #(.QueueDepth(QueueDepth), .RsDepth(RsDepth), .RobDepth(RobDepth)) i_dut (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .creditReturn(creditReturn),
        .commit(commit)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkCommit(input CommitPort got, input CommitPort exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: commit %0d gave rd %0d value %h invalid %0b",
                $time, committed, got.rd, got.value, got.invalid);
            $display("    expected rd %0d value %h invalid %0b",
                exp.rd, exp.value, exp.invalid);
            abortRun();
        end
    endtask

    task automatic checkCredits(input int held, input int low, input int high);
        if (held < low || held > high) begin
            $display("CHECK FAILED at %0t: sender holds %0d credits, allowed %0d to %0d",
                $time, held, low, high);
            abortRun();
        end
    endtask

    // ISA semantics of the supported subset where operand b is rs2 or the immediate
    function automatic logic [DataWidth-1:0] execute(input int op, input logic [31:0] a,
                                                     input logic [31:0] b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function automatic logic [2:0] funct3For(input int op);
        case (op)
            0, 1: return 3'b000;
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            5: return 3'b010;
            6: return 3'b001;
            default: return 3'b101;
        endcase
    endfunction

    task automatic sendRandom(input int regLow, input int regHigh);
        InstrWord w;
        CommitPort exp;
        int kind;
        int op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        logic [31:0] b;
        kind = $urandom_range(0, 15);
        rd = 5'($urandom_range(regLow, regHigh));
        rs1 = 5'($urandom_range(regLow, regHigh));
        rs2 = 5'($urandom_range(regLow, regHigh));
        imm = 12'($urandom);
        w = $urandom;
        exp = '{valid: 1'b1, rd: rd, value: '0, invalid: 1'b0};
        if (kind == 0) begin
            // Either an unsupported opcode or an M-extension encoding
            if ($urandom_range(0, 1) == 0) begin
                w.r.opcode = 7'b0000011;
            end else begin
                w.r.opcode = OpcodeOp;
                w.r.funct7 = 7'h01;
            end
            exp.rd = '0;
            exp.invalid = 1'b1;
        end else begin
            if (kind < 9) begin
                op = $urandom_range(0, 7);
                w.r = '{funct7: (op == 1) ? 7'h20 : 7'h00, rs2: rs2, rs1: rs1,
                        funct3: funct3For(op), rd: rd, opcode: OpcodeOp};
                b = regs[rs2];
            end else begin
                op = $urandom_range(0, 4);
                op = (op == 0) ? 0 : op + 1;
                w.i = '{imm12: imm, rs1: rs1, funct3: funct3For(op), rd: rd,
                        opcode: OpcodeOpImm};
                b = {{20{imm[11]}}, imm};
            end
            exp.value = execute(op, regs[rs1], b);
            if (rd != 0) regs[rd] = exp.value;
        end
        instr = w;
        instrValid = 1'b1;
        expected.push_back(exp);
    endtask

    task automatic observeOutputs();
        CommitPort exp;
        if (creditReturn) begin
            credits++;
            checkCredits(credits, 0, QueueDepth);
        end
        if (commit.valid) begin
            if (expected.size() == 0) begin
                $display("A commit arrived at %0t with no instruction outstanding", $time);
                abortRun();
            end else begin
                exp = expected.pop_front();
                checkCommit(commit, exp);
                committed++;
            end
        end
    endtask

    initial begin
        int stall;
        int cycles;
        bit chainPhase;
        void'($urandom(1));
        clk = 1'b0;
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        credits = QueueDepth;
        sent = 0;
        committed = 0;
        stall = 0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        while (sent < NumInstr) begin
            @(posedge clk);
            #1 instrValid = 1'b0;
            // Every other block of 200 is a dense chain over two registers
            chainPhase = ((sent / 200) % 2) == 1;
            if (credits > 0 && (chainPhase || $urandom_range(0, 3) != 0)) begin
                if (chainPhase) sendRandom(1, 2);
                else sendRandom(0, 4);
                credits--;
                sent++;
                stall = 0;
            end else if (credits == 0) begin
                stall++;
                if (stall > StallTimeout) begin
                    $display("Timed out at %0t: no credit came back for %0d cycles",
                        $time, StallTimeout);
                    abortRun();
                end
            end
            @(negedge clk);
            observeOutputs();
        end

        @(posedge clk);
        #1 instrValid = 1'b0;
        cycles = 0;
        while (committed < sent) begin
            @(negedge clk);
            observeOutputs();
            cycles++;
            if (cycles > DrainTimeout) begin
                $display("Timed out at %0t: only %0d of %0d instructions committed",
                    $time, committed, sent);
                abortRun();
            end
        end

        // Stray commits or credits would show up here
        repeat (20) begin
            @(negedge clk);
            observeOutputs();
        end
        checkCredits(credits, QueueDepth, QueueDepth);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/CorePkg.sv
verilog/InstrDecoder.sv
verilog/RenameTable.sv
verilog/ReservationStation.sv
verilog/IntAlu.sv
verilog/ReorderBuffer.sv
verilog/Core.sv
tb/Core_chk.sv
tb/CoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module CoreTb \
    --Mdir obj_dir -o CoreTb \
    -f vlog.f

./obj_dir/CoreTb
